/* logic/dsp_defines.svh */
////////////////////////////////////////////////////////////////////////////
// Widths, exponent bias and special values for the bfloat16 multiplier
// and the four-lane dot product
////////////////////////////////////////////////////////////////////////////
`ifndef DSP_DEFINES_SVH
`define DSP_DEFINES_SVH

// bfloat16 format
`define DSP_EXP_W    8
`define DSP_MAN_W    7        // Stored bits only
`define DSP_WORD_W   16
`define DSP_EXP_BIAS 127
`define DSP_EXP_MAX  255      // All-ones exponent
`define DSP_QNAN     16'h7fc0 // Positive quiet NaN

// Multiplier exception flags
`define DSP_FLAG_W   5

// Dot product datapath
`define DSP_FEAT_W   16
`define DSP_WGT_W    8
`define DSP_ACC_W    24       // Accumulator and chain
`define DSP_LANES    4

`endif

/* logic/dsp_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared types for the bfloat16 word, multiplier flags and stage payloads
// and the dot product lane
////////////////////////////////////////////////////////////////////////////
`include "dsp_defines.svh"

package dsp_pkg;

	// Decoded bfloat16 fields
	typedef struct packed {
		logic                  sign;
		logic [`DSP_EXP_W-1:0] exp;
		logic [`DSP_MAN_W-1:0] man;
	} bf16_fields_t;

	// One word read as a bus value or as fields
	typedef union packed {
		logic [`DSP_WORD_W-1:0] raw;
		bf16_fields_t           f;
	} bf16_word_u;

	// Exception flags, any is the OR of the rest
	typedef struct packed {
		logic any;
		logic a_nan;
		logic b_nan;
		logic a_inf;
		logic b_inf;
	} mul_flags_t;

	// Stage 1 payload
	typedef struct packed {
		logic                      sign;     // Product sign
		logic [`DSP_EXP_W-1:0]     exp_a;
		logic [`DSP_EXP_W-1:0]     exp_b;
		logic [2*`DSP_MAN_W+1:0]   man_prod; // 8x8 significand product
		logic                      zero;     // Either operand zero
		mul_flags_t                flags;
	} mul_prep_t;

	// Stage 2 payload
	typedef struct packed {
		logic                        sign;
		logic signed [`DSP_EXP_W+1:0] exp;   // Unbiased, may go negative
		logic [`DSP_MAN_W-1:0]       man;    // Kept bits
		logic                        guard;
		logic                        sticky;
		logic                        zero;
		mul_flags_t                  flags;
	} mul_norm_t;

	// One feature and its weight
	typedef struct packed {
		logic [`DSP_FEAT_W-1:0] feat;
		logic [`DSP_WGT_W-1:0]  wgt;
	} dot_lane_t;

endpackage

/* logic/bf16_mul_prep.sv */
////////////////////////////////////////////////////////////////////////////
// bfloat16 multiplier operand decode
// NaN and infinity detect plus significand product
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "dsp_defines.svh"

module bf16_mul_prep (
	input  dsp_pkg::bf16_word_u i_a,
	input  dsp_pkg::bf16_word_u i_b,
	output dsp_pkg::mul_prep_t  o_prep
);

	localparam int SIG_W = `DSP_MAN_W + 1; // With implicit one

	logic             a_exp_ones;
	logic             b_exp_ones;
	logic             a_nan;
	logic             b_nan;
	logic             a_inf;
	logic             b_inf;
	logic             a_zero;
	logic             b_zero;
	logic [SIG_W-1:0] a_sig;
	logic [SIG_W-1:0] b_sig;

	////////////////////////////////////////////////////////////////////////////
	// Field decode through the union
	////////////////////////////////////////////////////////////////////////////
	assign a_exp_ones = &i_a.f.exp;
	assign b_exp_ones = &i_b.f.exp;

	assign a_nan = a_exp_ones & (|i_a.f.man);   // Max exp, nonzero mantissa
	assign b_nan = b_exp_ones & (|i_b.f.man);
	assign a_inf = a_exp_ones & ~(|i_a.f.man);  // Max exp, zero mantissa
	assign b_inf = b_exp_ones & ~(|i_b.f.man);

	// Zero exponent treated as zero, subnormals flushed
	assign a_zero = ~(|i_a.f.exp);
	assign b_zero = ~(|i_b.f.exp);

	assign a_sig = {1'b1, i_a.f.man};
	assign b_sig = {1'b1, i_b.f.man};

	////////////////////////////////////////////////////////////////////////////
	// Stage 1 payload
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		o_prep.sign        = i_a.f.sign ^ i_b.f.sign;
		o_prep.exp_a       = i_a.f.exp;
		o_prep.exp_b       = i_b.f.exp;
		o_prep.man_prod    = {{SIG_W{1'b0}}, a_sig} * {{SIG_W{1'b0}}, b_sig};
		o_prep.zero        = a_zero | b_zero;
		o_prep.flags.a_nan = a_nan;
		o_prep.flags.b_nan = b_nan;
		o_prep.flags.a_inf = a_inf;
		o_prep.flags.b_inf = b_inf;
		o_prep.flags.any   = a_nan | b_nan | a_inf | b_inf;
	end

endmodule

/* logic/bf16_mul_norm_round.sv */
////////////////////////////////////////////////////////////////////////////
// bfloat16 multiplier normalize and round logic
// Round to nearest even with flush to zero and saturation to infinity
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "dsp_defines.svh"

module bf16_mul_norm_round (
	input  dsp_pkg::mul_prep_t  i_prep,
	output dsp_pkg::mul_norm_t  o_norm,
	input  dsp_pkg::mul_norm_t  i_norm,
	output dsp_pkg::bf16_word_u o_word,
	output dsp_pkg::mul_flags_t o_flags
);

	localparam int PW = 2 * (`DSP_MAN_W + 1);  // Product width
	localparam int EW = `DSP_EXP_W + 2;        // Signed exponent width
	localparam logic [EW-1:0] EXP_BIAS = EW'(`DSP_EXP_BIAS);

	logic                 top;      // Product in [2,4)
	logic [EW-1:0]        exp_sum;
	logic                 round_up;
	logic [`DSP_MAN_W:0]  man_rnd;  // Carry plus kept bits
	logic signed [EW-1:0] exp_rnd;
	logic                 is_nan;
	logic                 is_inf;
	logic                 flush;
	logic                 sat;

	////////////////////////////////////////////////////////////////////////////
	// Normalize half
	////////////////////////////////////////////////////////////////////////////
	assign top     = i_prep.man_prod[PW-1];
	assign exp_sum = {2'b00, i_prep.exp_a} + {2'b00, i_prep.exp_b}
		+ {{(EW-1){1'b0}}, top} - EXP_BIAS;

	always_comb begin
		o_norm.sign  = i_prep.sign;
		o_norm.exp   = exp_sum;
		o_norm.zero  = i_prep.zero;
		o_norm.flags = i_prep.flags;
		if (top) begin // Shift by one
			o_norm.man    = i_prep.man_prod[PW-2 -: `DSP_MAN_W];
			o_norm.guard  = i_prep.man_prod[PW-2-`DSP_MAN_W];
			o_norm.sticky = |i_prep.man_prod[PW-3-`DSP_MAN_W:0];
		end else begin
			o_norm.man    = i_prep.man_prod[PW-3 -: `DSP_MAN_W];
			o_norm.guard  = i_prep.man_prod[PW-3-`DSP_MAN_W];
			o_norm.sticky = |i_prep.man_prod[PW-4-`DSP_MAN_W:0];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Round half
	////////////////////////////////////////////////////////////////////////////
	// Ties go to the even mantissa
	assign round_up = i_norm.guard & (i_norm.sticky | i_norm.man[0]);
	assign man_rnd  = {1'b0, i_norm.man} + {{`DSP_MAN_W{1'b0}}, round_up};
	assign exp_rnd  = i_norm.exp + {{(EW-1){1'b0}}, man_rnd[`DSP_MAN_W]}; // Carry bump

	// Inf times zero is invalid
	assign is_nan = i_norm.flags.a_nan | i_norm.flags.b_nan
		| ((i_norm.flags.a_inf | i_norm.flags.b_inf) & i_norm.zero);
	assign is_inf = i_norm.flags.a_inf | i_norm.flags.b_inf;
	assign flush  = i_norm.zero | (exp_rnd <= 0);
	assign sat    = exp_rnd >= `DSP_EXP_MAX;

	// Priority NaN then inf then zero
	always_comb begin
		o_flags       = i_norm.flags;   // Unchanged
		o_word.f.sign = i_norm.sign;
		o_word.f.exp  = '0;
		o_word.f.man  = '0;
		if (is_nan) begin
			o_word.raw = `DSP_QNAN;
		end else if (is_inf || (!flush && sat)) begin
			o_word.f.exp = '1;            // Signed infinity
		end else if (!flush) begin
			o_word.f.exp = exp_rnd[`DSP_EXP_W-1:0];
			o_word.f.man = man_rnd[`DSP_MAN_W-1:0];
		end
	end

endmodule

/* logic/bf16_mul.sv */
////////////////////////////////////////////////////////////////////////////
// Four-stage bfloat16 multiplier
// Operand, prep, normalize and output registers
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "dsp_defines.svh"

module bf16_mul (
	input  logic                clk,
	input  logic                reset,
	input  dsp_pkg::bf16_word_u i_a,
	input  dsp_pkg::bf16_word_u i_b,
	output dsp_pkg::bf16_word_u o_product,
	output dsp_pkg::mul_flags_t o_flags
);

	dsp_pkg::bf16_word_u    r_a;        // Stage 0 operands
	dsp_pkg::bf16_word_u    r_b;
	dsp_pkg::mul_prep_t     prep;
	dsp_pkg::mul_prep_t     r_prep;     // Stage 1
	dsp_pkg::mul_norm_t     norm;
	dsp_pkg::mul_norm_t     r_norm;     // Stage 2
	dsp_pkg::bf16_word_u    word;
	dsp_pkg::mul_flags_t    flags;
	dsp_pkg::bf16_word_u    r_word;     // Stage 3
	dsp_pkg::mul_flags_t    r_flags;
	logic [`DSP_FLAG_W-1:0] flag_bits;

	bf16_mul_prep u_prep (
		.i_a    (r_a),
		.i_b    (r_b),
		.o_prep (prep)
	);

	bf16_mul_norm_round u_norm_round (
		.i_prep  (r_prep),
		.o_norm  (norm),
		.i_norm  (r_norm),
		.o_word  (word),
		.o_flags (flags)
	);

	////////////////////////////////////////////////////////////////////////////
	// Pipeline registers
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			r_a     <= '0;
			r_b     <= '0;
			r_prep  <= '0;
			r_norm  <= '0;
			r_word  <= '0;
			r_flags <= '0;
		end else begin
			r_a     <= i_a;      // Sample every edge
			r_b     <= i_b;
			r_prep  <= prep;
			r_norm  <= norm;
			r_word  <= word;
			r_flags <= flags;
		end
	end

	assign o_product = r_word;
	assign o_flags   = r_flags;

	// Summary flag consistent after three stages of transport
	assign flag_bits = r_flags;

	a_any_flag: assert property (@(posedge clk) disable iff (reset)
		flag_bits[`DSP_FLAG_W-1] == (|flag_bits[`DSP_FLAG_W-2:0]));

endmodule

/* logic/sop2_block.sv */
////////////////////////////////////////////////////////////////////////////
// Two-product sum of products with chain input
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "dsp_defines.svh"

module sop2_block (
	input  logic                  clk,
	input  logic                  reset,
	input  dsp_pkg::dot_lane_t    i_pair_a,
	input  dsp_pkg::dot_lane_t    i_pair_b,
	input  logic [`DSP_ACC_W-1:0] i_chain,
	output logic [`DSP_ACC_W-1:0] o_result
);

	localparam int ACC_W = `DSP_ACC_W;

	dsp_pkg::dot_lane_t r_pair_a;    // Input registers
	dsp_pkg::dot_lane_t r_pair_b;
	logic [ACC_W-1:0]   prod_a;
	logic [ACC_W-1:0]   prod_b;

	// Unsigned 16x8 products
	assign prod_a = ACC_W'(r_pair_a.feat) * ACC_W'(r_pair_a.wgt);
	assign prod_b = ACC_W'(r_pair_b.feat) * ACC_W'(r_pair_b.wgt);

	always_ff @(posedge clk) begin
		if (reset) begin
			r_pair_a <= '0;
			r_pair_b <= '0;
			o_result <= '0;
		end else begin
			r_pair_a <= i_pair_a;
			r_pair_b <= i_pair_b;
			o_result <= prod_a + prod_b + i_chain; // Wraps modulo 2^24
		end
	end

	// First result out of reset built from cleared inputs and chain
	a_reset_clears: assert property (@(posedge clk)
		$fell(reset) |=> (o_result == '0));

endmodule

/* logic/dot_product_4.sv */
////////////////////////////////////////////////////////////////////////////
// Four-lane unsigned dot product
// Lane skew registers and two chained sum of products blocks
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "dsp_defines.svh"

module dot_product_4 (
	input  logic                                 clk,
	input  logic                                 reset,
	input  dsp_pkg::dot_lane_t [`DSP_LANES-1:0]  i_lanes,
	output logic [`DSP_ACC_W-1:0]                o_result
);

	dsp_pkg::dot_lane_t [1:0]  r_skew_lo;    // Lanes 0 and 1
	dsp_pkg::dot_lane_t [1:0]  r_skew_hi_0;  // Lanes 2 and 3 first stage
	dsp_pkg::dot_lane_t [1:0]  r_skew_hi_1;  // Second stage
	logic [`DSP_ACC_W-1:0]     chain;        // Partial sum lanes 0 and 1

	////////////////////////////////////////////////////////////////////////////
	// Skew so the upper block meets its own sample on the chain
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			r_skew_lo   <= '0;
			r_skew_hi_0 <= '0;
			r_skew_hi_1 <= '0;
		end else begin
			r_skew_lo   <= i_lanes[1:0];
			r_skew_hi_0 <= i_lanes[3:2];
			r_skew_hi_1 <= r_skew_hi_0;
		end
	end

	sop2_block u_sop_lo (
		.clk      (clk),
		.reset    (reset),
		.i_pair_a (r_skew_lo[0]),
		.i_pair_b (r_skew_lo[1]),
		.i_chain  ('0),            // Head of chain
		.o_result (chain)
	);

	sop2_block u_sop_hi (
		.clk      (clk),
		.reset    (reset),
		.i_pair_a (r_skew_hi_1[0]),
		.i_pair_b (r_skew_hi_1[1]),
		.i_chain  (chain),
		.o_result (o_result)
	);

	// Full pipeline flushed with known values
	a_no_x: assert property (@(posedge clk) disable iff (reset)
		(!$past(reset, 1) && !$past(reset, 2) && !$past(reset, 3))
		|-> !$isunknown(o_result));

endmodule

/* logic/dsp_regression_top.sv */
////////////////////////////////////////////////////////////////////////////
// DSP regression top with bfloat16 multiplier and dot product
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "dsp_defines.svh"

module dsp_regression_top (
	input  logic                                clk,
	input  logic                                reset,
	// Multiplier
	input  dsp_pkg::bf16_word_u                 i_a,
	input  dsp_pkg::bf16_word_u                 i_b,
	output dsp_pkg::bf16_word_u                 o_product,
	output dsp_pkg::mul_flags_t                 o_flags,
	// Dot product
	input  dsp_pkg::dot_lane_t [`DSP_LANES-1:0] i_lanes,
	output logic [`DSP_ACC_W-1:0]               o_dot_result
);

	// Four cycles operand to product
	bf16_mul u_bf16_mul (
		.clk       (clk),
		.reset     (reset),
		.i_a       (i_a),
		.i_b       (i_b),
		.o_product (o_product),
		.o_flags   (o_flags)
	);

	// Four cycles lanes to sum
	dot_product_4 u_dot_product_4 (
		.clk      (clk),
		.reset    (reset),
		.i_lanes  (i_lanes),
		.o_result (o_dot_result)
	);

endmodule

/* dv/dsp_ref_model.svh */
////////////////////////////////////////////////////////////////////////////
// Reference model for the bfloat16 product, its flags and the dot product
////////////////////////////////////////////////////////////////////////////
`ifndef DSP_REF_MODEL_SVH
`define DSP_REF_MODEL_SVH

// bfloat16 product with flush to zero and saturation to infinity
function automatic logic [15:0] bf16_multiply(input logic [15:0] a, input logic [15:0] b);
	logic        sign;
	logic [7:0]  ea;
	logic [7:0]  eb;
	logic        a_nan;
	logic        b_nan;
	logic        a_inf;
	logic        b_inf;
	logic        a_zero;
	logic        b_zero;
	logic [15:0] sig;     // Significand product
	logic [7:0]  man;     // Hidden one plus 7 kept bits
	logic        guard;
	logic        sticky;
	int          e_sum;   // Unbiased exponent
	sign   = a[15] ^ b[15];
	ea     = a[14:7];
	eb     = b[14:7];
	a_nan  = (ea == 8'hff) && (a[6:0] != 7'h00);
	b_nan  = (eb == 8'hff) && (b[6:0] != 7'h00);
	a_inf  = (ea == 8'hff) && (a[6:0] == 7'h00);
	b_inf  = (eb == 8'hff) && (b[6:0] == 7'h00);
	a_zero = (ea == 8'h00);   // Subnormals count as zero
	b_zero = (eb == 8'h00);
	if (a_nan || b_nan || ((a_inf || b_inf) && (a_zero || b_zero)))
		return `DSP_QNAN;
	if (a_inf || b_inf)
		return {sign, 8'hff, 7'h00};
	if (a_zero || b_zero)
		return {sign, 15'h0000};
	sig   = {8'h00, 1'b1, a[6:0]} * {8'h00, 1'b1, b[6:0]};
	e_sum = int'(ea) + int'(eb) - `DSP_EXP_BIAS;
	if (sig[15])
		e_sum = e_sum + 1;    // Product in [2,4)
	else
		sig = sig << 1;       // Leading one up to bit 15
	man    = sig[15:8];
	guard  = sig[7];
	sticky = |sig[6:0];
	// Nearest even
	if (guard && (sticky || man[0])) begin
		if (man == 8'hff) begin
			man   = 8'h80;      // Rolls over to 2.0
			e_sum = e_sum + 1;
		end else begin
			man = man + 8'h01;
		end
	end
	if (e_sum <= 0)
		return {sign, 15'h0000};
	if (e_sum >= `DSP_EXP_MAX)
		return {sign, 8'hff, 7'h00};
	return {sign, e_sum[7:0], man[6:0]};
endfunction

// Per-operand NaN and infinity flags
function automatic dsp_pkg::mul_flags_t operand_flags(input logic [15:0] a, input logic [15:0] b);
	dsp_pkg::mul_flags_t fl;
	fl.a_nan = (a[14:7] == 8'hff) && (a[6:0] != 7'h00);
	fl.b_nan = (b[14:7] == 8'hff) && (b[6:0] != 7'h00);
	fl.a_inf = (a[14:7] == 8'hff) && (a[6:0] == 7'h00);
	fl.b_inf = (b[14:7] == 8'hff) && (b[6:0] == 7'h00);
	fl.any   = fl.a_nan | fl.b_nan | fl.a_inf | fl.b_inf;
	return fl;
endfunction

// Sum of four unsigned products
function automatic logic [`DSP_ACC_W-1:0] lane_dot_sum(
	input dsp_pkg::dot_lane_t [`DSP_LANES-1:0] lanes);
	logic [31:0] total;
	total = 32'h0;
	for (int i = 0; i < `DSP_LANES; i++)
		total = total + 32'(lanes[i].feat) * 32'(lanes[i].wgt);
	return total[`DSP_ACC_W-1:0];   // Modulo 2^24
endfunction

`endif

/* dv/dsp_regression_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the DSP regression top
// Directed and random stimulus, delayed expectations, output checks
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "dsp_defines.svh"

module dsp_regression_tb;

	localparam int          LATENCY      = 4;     // Both datapaths
	localparam int          RESET_CYCLES = 16;
	localparam int          NUM_RANDOM   = 2000;
	localparam int          MAX_CYCLES   = RESET_CYCLES + NUM_RANDOM + 184; // Directed and drain
	localparam logic [31:0] SEED         = 32'h72f3_a316;

	// Expected outputs of one sample
	typedef struct packed {
		logic [`DSP_WORD_W-1:0] product;
		dsp_pkg::mul_flags_t    flags;
		logic [`DSP_ACC_W-1:0]  dot;
	} expect_t;

	logic                                clk;
	logic                                reset;
	dsp_pkg::bf16_word_u                 i_a;
	dsp_pkg::bf16_word_u                 i_b;
	dsp_pkg::dot_lane_t [`DSP_LANES-1:0] i_lanes;
	dsp_pkg::bf16_word_u                 o_product;
	dsp_pkg::mul_flags_t                 o_flags;
	logic [`DSP_ACC_W-1:0]               o_dot_result;
	expect_t                             exp_cur;              // Sample driven this cycle
	expect_t                             exp_line [LATENCY];   // Oldest at the end
	int                                  cycle_count = 0;

	`include "dsp_ref_model.svh"

	dsp_regression_top u_dsp_regression_top (
		.clk          (clk),
		.reset        (reset),
		.i_a          (i_a),
		.i_b          (i_b),
		.i_lanes      (i_lanes),
		.o_product    (o_product),
		.o_flags      (o_flags),
		.o_dot_result (o_dot_result)
	);

	always #5 clk = ~clk;   // 10 ns period

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////
	// One cycle of inputs, 1 ns after the edge
	task automatic drive_cycle(input logic rst, input logic [15:0] a, input logic [15:0] b,
		input dsp_pkg::dot_lane_t [`DSP_LANES-1:0] lanes);
		@(posedge clk);
		#1;
		reset   = rst;
		i_a.raw = a;
		i_b.raw = b;
		i_lanes = lanes;
		if (rst) begin
			exp_cur = '0;   // Sampled in reset, dropped
		end else begin
			exp_cur.product = bf16_multiply(a, b);
			exp_cur.flags   = operand_flags(a, b);
			exp_cur.dot     = lane_dot_sum(lanes);
		end
	endtask

	task automatic drive_mul(input logic [15:0] a, input logic [15:0] b);
		drive_cycle(1'b0, a, b, '0);
	endtask

	// Only one lane nonzero
	task automatic drive_lane(input int pos, input logic [15:0] feat, input logic [7:0] wgt);
		dsp_pkg::dot_lane_t [`DSP_LANES-1:0] lanes;
		lanes           = '0;
		lanes[pos].feat = feat;
		lanes[pos].wgt  = wgt;
		drive_cycle(1'b0, 16'h0000, 16'h0000, lanes);
	endtask

	// Mostly moderate exponents, one in four fully random
	function automatic logic [15:0] random_operand();
		logic [31:0] r;
		logic [15:0] w;
		r = $urandom;
		w = r[15:0];
		if (r[31:30] != 2'b00)
			w[14:7] = 8'd96 + {2'b00, r[21:16]};
		return w;
	endfunction

	task automatic drive_random();
		logic [15:0]                         a;
		logic [15:0]                         b;
		dsp_pkg::dot_lane_t [`DSP_LANES-1:0] lanes;
		a = random_operand();
		b = random_operand();
		for (int l = 0; l < `DSP_LANES; l++) begin
			lanes[l].feat = 16'($urandom);
			lanes[l].wgt  = 8'($urandom);
		end
		drive_cycle(1'b0, a, b, lanes);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checking
	////////////////////////////////////////////////////////////////////////////
	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, expected);
			$display("TEST FAILED");
			$fatal(1, "Output mismatch on %s", name);
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		check_value("o_product", o_product.raw, exp_line[LATENCY-1].product);
		check_value("o_flags", o_flags, exp_line[LATENCY-1].flags);
		check_value("o_dot_result", o_dot_result, exp_line[LATENCY-1].dot);
		for (int i = LATENCY - 1; i > 0; i--)
			exp_line[i] = exp_line[i-1];
		exp_line[0] = exp_cur;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin
		clk     = 1'b0;
		reset   = 1'b1;
		i_a     = '0;
		i_b     = '0;
		i_lanes = '0;
		exp_cur = '0;
		foreach (exp_line[i])
			exp_line[i] = '0;
		void'($urandom(SEED));
		// Busy inputs during reset must not leak out
		repeat (RESET_CYCLES - 1) drive_cycle(1'b1, 16'h3f80, 16'h4040, '1);

		// Normal products
		drive_mul(16'h3f80, 16'h3f80);   // 1.0 x 1.0
		drive_mul(16'h3fc0, 16'h3fc0);   // 2.25 needs the shift
		drive_mul(16'h3f81, 16'h3fc0);   // Tie, odd rounds up
		drive_mul(16'h3f83, 16'h3fc0);   // Tie, even stays
		drive_mul(16'h3fb5, 16'h3fb5);   // Round carries into exponent
		drive_mul(16'hbf80, 16'h4040);   // Negative
		// Exceptions
		drive_mul(16'h7fc1, 16'h3f80);   // NaN a
		drive_mul(16'h3f80, 16'hff81);   // NaN b
		drive_mul(16'h7fc0, 16'h7f80);   // NaN times inf
		drive_mul(16'h7f80, 16'h4000);
		drive_mul(16'hff80, 16'h4000);   // Negative inf
		drive_mul(16'h7f80, 16'hff80);   // Both inf
		drive_mul(16'h7f80, 16'h0000);   // Inf times zero
		drive_mul(16'h8000, 16'hff80);
		drive_mul(16'h0000, 16'h3f80);
		drive_mul(16'h8000, 16'h3f80);   // Signed zero
		drive_mul(16'h0001, 16'h4000);   // Subnormal flushed
		// Exponent range limits
		drive_mul(16'h7f00, 16'h7f00);   // Overflow
		drive_mul(16'hff00, 16'h7f00);
		drive_mul(16'h7f7f, 16'h3f80);   // Max normal kept
		drive_mul(16'h5f35, 16'h5fb5);   // Rounds past max
		drive_mul(16'h0080, 16'h0080);   // Underflow
		drive_mul(16'h8080, 16'h0080);
		drive_mul(16'h0100, 16'h3f00);   // Smallest normal
		drive_mul(16'h0080, 16'h3f00);

		// Dot product wrap, then each lane alone back to back
		drive_cycle(1'b0, 16'h0000, 16'h0000, '1);
		for (int p = 0; p < `DSP_LANES; p++)
			drive_lane(p, 16'(16'h1000 + p * 16'h0111), 8'(8'h11 * (p + 1)));
		for (int p = 0; p < `DSP_LANES; p++)
			drive_lane(p, 16'hffff, 8'hff);

		// Both datapaths together, one sample per cycle
		repeat (NUM_RANDOM) drive_random();

		// Drain the pipelines
		repeat (LATENCY + 1) drive_mul(16'h0000, 16'h0000);
		$display("TEST PASSED");
		$finish;
	end

endmodule

/* dsp_regression.f */
+incdir+logic
+incdir+dv
logic/dsp_pkg.sv
logic/bf16_mul_prep.sv
logic/bf16_mul_norm_round.sv
logic/bf16_mul.sv
logic/sop2_block.sv
logic/dot_product_4.sv
logic/dsp_regression_top.sv
dv/dsp_regression_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the DSP regression with Verilator and run it from the project root
# Pass or fail comes from the pass message in the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module dsp_regression_tb \
	-f dsp_regression.f \
	&& ./obj_dir/Vdsp_regression_tb 2>&1 | tee /dev/stderr | grep -q "^TEST PASSED$" \
	&& echo "Regression run passed" \
	|| { echo "Regression run failed"; exit 1; }
